//--- rv32_decoder.f
source/riscv_isa_pkg.sv
source/decode_out_pkg.sv
source/decode_if.sv
source/instr_type_decode.sv
source/operand_extract.sv
source/decode_result_reg.sv
source/rv32_decoder.sv
sim/rv32_decoder_chk.sv
sim/rv32_decoder_tb.sv

//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      ?= rv32_decoder_tb
RTL_TOP  ?= rv32_decoder
FILELIST ?= rv32_decoder.f
OBJ_DIR  ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(SIM) --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		--top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/rv32_decoder_tb.sv
/*
 * Testbench for the RV32I/M decoder
 * Table-driven and LFSR-driven instructions checked one cycle after each strobe
 */
`timescale 1ns/1ps
`default_nettype none

module rv32_decoder_tb;

    typedef struct packed {
        riscv_isa_pkg::instr_t    instr;
        decode_out_pkg::op_type_t op;
        decode_out_pkg::reg_idx_t rd;
        decode_out_pkg::reg_idx_t rs1;
        decode_out_pkg::reg_idx_t rs2;
        decode_out_pkg::imm_t     imm;
        logic                     load_rs;
        logic                     illegal;
    } vector_t;

    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_COUNT = 40;

    logic                     clk;
    logic                     rst;
    logic                     stb;
    riscv_isa_pkg::instr_t    instr;
    decode_out_pkg::op_type_t op_type;
    decode_out_pkg::reg_idx_t rd;
    decode_out_pkg::reg_idx_t rs1;
    decode_out_pkg::reg_idx_t rs2;
    decode_out_pkg::imm_t     imm;
    logic                     load_rs;
    logic                     ack;
    logic                     err;

    vector_t     vectors[$];
    vector_t     pending;        // Instruction whose response is due next
    logic        pending_valid;
    vector_t     held;           // Last strobed instruction still on the outputs
    logic        held_valid;
    vector_t     idle_vec;
    logic [15:0] lfsr_state;

    rv32_decoder #(
        .ENABLE_M (1'b1)
    ) u_dut (
        .clk_i     (clk),
        .rst_i     (rst),
        .stb_i     (stb),
        .instr_i   (instr),
        .op_type_o (op_type),
        .rd_o      (rd),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .imm_o     (imm),
        .load_rs_o (load_rs),
        .ack_o     (ack),
        .err_o     (err)
    );

    always #5 clk = ~clk;  // 10 ns period

    // ============================================================
    // Failure reporting and compare tasks
    // ============================================================
    task automatic report_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_op(input decode_out_pkg::op_type_t got, exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_reg(input decode_out_pkg::reg_idx_t got, exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("%s is x%0d, expected x%0d", what, got, exp));
        end
    endtask

    task automatic check_imm(input decode_out_pkg::imm_t got, exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("%s is %08h, expected %08h", what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, exp, input string what);
        if (got !== exp) begin
            report_fail($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // ============================================================
    // Stimulus table
    // ============================================================
    task automatic add_legal(input riscv_isa_pkg::instr_t word,
                             input decode_out_pkg::op_type_t exp_op,
                             input decode_out_pkg::reg_idx_t exp_rd, exp_rs1, exp_rs2,
                             input decode_out_pkg::imm_t exp_imm, input logic exp_load);
        vector_t vec;
        vec = '{word, exp_op, exp_rd, exp_rs1, exp_rs2, exp_imm, exp_load, 1'b0};
        vectors.push_back(vec);
    endtask

    task automatic add_illegal(input riscv_isa_pkg::instr_t word);
        vector_t vec;
        vec         = '0;
        vec.instr   = word;
        vec.illegal = 1'b1;
        vectors.push_back(vec);
    endtask

    task automatic build_vectors();
        // U and J formats with immediate bits in the rs1 and rs2 positions
        add_legal(32'h123452B7, decode_out_pkg::OP_LUI, 5'd5, 5'd0, 5'd0, 32'h12345000, 1'b0);
        add_legal(32'hFFFFF517, decode_out_pkg::OP_AUIPC, 5'd10, 5'd0, 5'd0, 32'hFFFFF000, 1'b0);
        add_legal(32'hFFDFF0EF, decode_out_pkg::OP_JAL, 5'd1, 5'd0, 5'd0, 32'hFFFFFFFC, 1'b0);
        add_legal(32'h0010106F, decode_out_pkg::OP_JAL, 5'd0, 5'd0, 5'd0, 32'h00001800, 1'b0);
        add_legal(32'h010100E7, decode_out_pkg::OP_JALR, 5'd1, 5'd2, 5'd0, 32'h00000010, 1'b1);
        // Branches, loads, stores
        add_legal(32'hFE208CE3, decode_out_pkg::OP_BEQ, 5'd0, 5'd1, 5'd2, 32'hFFFFFFF8, 1'b1);
        add_legal(32'h0041F8E3, decode_out_pkg::OP_BGEU, 5'd0, 5'd3, 5'd4, 32'h00000810, 1'b1);
        add_legal(32'hFFF3A303, decode_out_pkg::OP_LW, 5'd6, 5'd7, 5'd0, 32'hFFFFFFFF, 1'b1);
        add_legal(32'h7FF4C403, decode_out_pkg::OP_LBU, 5'd8, 5'd9, 5'd0, 32'h000007FF, 1'b1);
        add_legal(32'hFEB62E23, decode_out_pkg::OP_SW, 5'd0, 5'd12, 5'd11, 32'hFFFFFFFC, 1'b1);
        add_legal(32'h04D702A3, decode_out_pkg::OP_SB, 5'd0, 5'd14, 5'd13, 32'h00000045, 1'b1);
        // Register-immediate and register-register ALU
        add_legal(32'h80000093, decode_out_pkg::OP_ADDI, 5'd1, 5'd0, 5'd0, 32'hFFFFF800, 1'b1);
        add_legal(32'h40735293, decode_out_pkg::OP_SRAI, 5'd5, 5'd6, 5'd0, 32'h00000407, 1'b1);
        add_legal(32'h01F19113, decode_out_pkg::OP_SLLI, 5'd2, 5'd3, 5'd0, 32'h0000001F, 1'b1);
        add_legal(32'h005201B3, decode_out_pkg::OP_ADD, 5'd3, 5'd4, 5'd5, 32'h0, 1'b1);
        add_legal(32'h41DF0FB3, decode_out_pkg::OP_SUB, 5'd31, 5'd30, 5'd29, 32'h0, 1'b1);
        add_legal(32'h003170B3, decode_out_pkg::OP_AND, 5'd1, 5'd2, 5'd3, 32'h0, 1'b1);
        // Fence and system
        add_legal(32'h0FF0000F, decode_out_pkg::OP_FENCE, 5'd0, 5'd0, 5'd0, 32'h000000FF, 1'b1);
        add_legal(32'h00000073, decode_out_pkg::OP_ECALL, 5'd0, 5'd0, 5'd0, 32'h0, 1'b0);
        add_legal(32'h00100073, decode_out_pkg::OP_EBREAK, 5'd0, 5'd0, 5'd0, 32'h0, 1'b0);
        add_legal(32'h30200073, decode_out_pkg::OP_MRET, 5'd0, 5'd0, 5'd0, 32'h0, 1'b0);
        add_legal(32'h10500073, decode_out_pkg::OP_WFI, 5'd0, 5'd0, 5'd0, 32'h0, 1'b0);
        // RV32M with x3 = x1 op x2
        add_legal(32'h022081B3, decode_out_pkg::OP_MUL, 5'd3, 5'd1, 5'd2, 32'h0, 1'b1);
        add_legal(32'h022091B3, decode_out_pkg::OP_MULH, 5'd3, 5'd1, 5'd2, 32'h0, 1'b1);
        add_legal(32'h0220A1B3, decode_out_pkg::OP_MULHSU, 5'd3, 5'd1, 5'd2, 32'h0, 1'b1);
        add_legal(32'h0220B1B3, decode_out_pkg::OP_MULHU, 5'd3, 5'd1, 5'd2, 32'h0, 1'b1);
        add_legal(32'h0220C1B3, decode_out_pkg::OP_DIV, 5'd3, 5'd1, 5'd2, 32'h0, 1'b1);
        add_legal(32'h0220D1B3, decode_out_pkg::OP_DIVU, 5'd3, 5'd1, 5'd2, 32'h0, 1'b1);
        add_legal(32'h0220E1B3, decode_out_pkg::OP_REM, 5'd3, 5'd1, 5'd2, 32'h0, 1'b1);
        add_legal(32'h0220F1B3, decode_out_pkg::OP_REMU, 5'd3, 5'd1, 5'd2, 32'h0, 1'b1);
        // Illegal encodings
        add_illegal(32'h0000007F);  // Unknown opcode
        add_illegal(32'h00002063);  // Branch funct3 010
        add_illegal(32'h02001013);  // SLLI with nonzero funct7
        add_illegal(32'h300110F3);  // CSRRW
        add_illegal(32'h00200073);  // Unsupported funct12
    endtask

    // ============================================================
    // Drive and check one cycle per call
    // ============================================================
    task automatic check_fields(input vector_t exp, input string tag);
        check_op(op_type, exp.op, {"op_type_o for ", tag});
        check_reg(rd, exp.rd, {"rd_o for ", tag});
        check_reg(rs1, exp.rs1, {"rs1_o for ", tag});
        check_reg(rs2, exp.rs2, {"rs2_o for ", tag});
        check_imm(imm, exp.imm, {"imm_o for ", tag});
        check_bit(load_rs, exp.load_rs, {"load_rs_o for ", tag});
    endtask

    task automatic check_response();
        string tag;
        tag = $sformatf("instruction %08h", pending.instr);
        if (!pending_valid) begin
            check_bit(ack, 1'b0, "ack_o on a cycle without strobe");
            check_bit(err, 1'b0, "err_o on a cycle without strobe");
            if (held_valid) begin
                check_fields(held, $sformatf("held instruction %08h", held.instr));
            end
        end else if (pending.illegal) begin
            check_bit(err, 1'b1, {"err_o for illegal ", tag});
            check_bit(ack, 1'b0, {"ack_o for illegal ", tag});
        end else begin
            check_bit(ack, 1'b1, {"ack_o for ", tag});
            check_bit(err, 1'b0, {"err_o for ", tag});
            check_fields(pending, tag);
        end
    endtask

    task automatic apply_cycle(input logic strobe, input vector_t vec);
        @(posedge clk);
        stb   <= strobe;
        instr <= vec.instr;
        @(negedge clk);
        check_response();  // Answer to the previous cycle's drive
        pending       = vec;
        pending_valid = strobe;
        if (strobe) begin
            held       = vec;
            held_valid = !vec.illegal;  // Fields after an error are unspecified
        end
    endtask

    task automatic run_random();
        vector_t     vec;
        logic [31:0] word;
        logic [11:0] imm12;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            vec     = '0;
            word    = take_bits(5);
            vec.rd  = word[4:0];
            word    = take_bits(5);
            vec.rs1 = word[4:0];
            vec.load_rs = 1'b1;
            word    = take_bits(1);
            if (word[0]) begin
                word      = take_bits(12);
                imm12     = word[11:0];
                vec.op    = decode_out_pkg::OP_ADDI;
                vec.imm   = {{20{imm12[11]}}, imm12};
                vec.instr = {imm12, vec.rs1, 3'b000, vec.rd, riscv_isa_pkg::OPC_OP_IMM};
            end else begin
                word      = take_bits(5);
                vec.rs2   = word[4:0];
                vec.op    = decode_out_pkg::OP_ADD;
                vec.instr = {riscv_isa_pkg::F7_BASE, vec.rs2, vec.rs1, 3'b000, vec.rd,
                             riscv_isa_pkg::OPC_OP};
            end
            apply_cycle(1'b1, vec);
            if (i == RANDOM_COUNT / 2) begin
                apply_cycle(1'b0, idle_vec);  // Gap in the middle of the stream
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        stb           = 1'b0;
        instr         = '0;
        pending       = '0;
        pending_valid = 1'b0;
        held          = '0;
        held_valid    = 1'b0;
        idle_vec      = '0;
        lfsr_state    = 16'd25548;
        build_vectors();

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        foreach (vectors[i]) begin
            apply_cycle(1'b1, vectors[i]);  // Back-to-back strobes
        end
        apply_cycle(1'b0, idle_vec);
        apply_cycle(1'b0, idle_vec);
        run_random();
        apply_cycle(1'b0, idle_vec);
        apply_cycle(1'b0, idle_vec);

        $display("RESULT: PASS");
        $finish;
    end

    // Watchdog sized at four cycles per instruction plus reset
    initial begin
        int limit;
        #1;
        limit = (RESET_CYCLES + vectors.size() + RANDOM_COUNT) * 4;
        repeat (limit) @(posedge clk);
        $display("Timeout: the decoder run did not finish within %0d cycles", limit);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- sim/rv32_decoder_chk.sv
/*
 * Response pulse checks for the decoder
 * Bound to the top level, one pulse per strobe on the next cycle
 */
`timescale 1ns/1ps
`default_nettype none

module rv32_decoder_chk (
    input logic clk_i,
    input logic rst_i,
    input logic stb_i,
    input logic ack_i,
    input logic err_i
);

    ack_err_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(ack_i && err_i))
        else $error("ack and err are high in the same cycle");

    strobe_answered: assert property (@(posedge clk_i) disable iff (rst_i)
        stb_i |=> (ack_i ^ err_i))  // Exactly one of the two
        else $error("strobe not followed by exactly one response pulse");

    no_unrequested_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        (ack_i || err_i) |-> $past(stb_i))
        else $error("response pulse without a strobe in the cycle before");

endmodule

bind rv32_decoder rv32_decoder_chk u_chk (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .stb_i (stb_i),
    .ack_i (ack_o),
    .err_i (err_o)
);

`default_nettype wire

//--- source/rv32_decoder.sv
/*
 * RV32I/M instruction decoder, top level
 * One-cycle decode of a strobed instruction into operation and operands
 */
`timescale 1ns/1ps
`default_nettype none

module rv32_decoder #(
    parameter bit ENABLE_M = 1'b1  // Accept the RV32M encodings
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     stb_i,
    input  riscv_isa_pkg::instr_t    instr_i,
    output decode_out_pkg::op_type_t op_type_o,
    output decode_out_pkg::reg_idx_t rd_o,
    output decode_out_pkg::reg_idx_t rs1_o,
    output decode_out_pkg::reg_idx_t rs2_o,
    output decode_out_pkg::imm_t     imm_o,
    output logic                     load_rs_o,
    output logic                     ack_o,
    output logic                     err_o
);

    decode_if u_dec_if ();

    instr_type_decode #(
        .ENABLE_M (ENABLE_M)
    ) u_type (
        .instr_i (instr_i),
        .dec_o   (u_dec_if)
    );

    operand_extract u_operand (
        .instr_i (instr_i),
        .dec_o   (u_dec_if)
    );

    decode_result_reg u_result (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stb_i     (stb_i),
        .dec_i     (u_dec_if),
        .op_type_o (op_type_o),
        .rd_o      (rd_o),
        .rs1_o     (rs1_o),
        .rs2_o     (rs2_o),
        .imm_o     (imm_o),
        .load_rs_o (load_rs_o),
        .ack_o     (ack_o),
        .err_o     (err_o)
    );

endmodule

`default_nettype wire

//--- source/decode_result_reg.sv
/*
 * Decode result register
 * Captures the fields on a strobe and answers with an ack or error pulse
 */
`timescale 1ns/1ps
`default_nettype none

module decode_result_reg (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     stb_i,
    decode_if.result_mp              dec_i,
    output decode_out_pkg::op_type_t op_type_o,
    output decode_out_pkg::reg_idx_t rd_o,
    output decode_out_pkg::reg_idx_t rs1_o,
    output decode_out_pkg::reg_idx_t rs2_o,
    output decode_out_pkg::imm_t     imm_o,
    output logic                     load_rs_o,
    output logic                     ack_o,
    output logic                     err_o
);

    // Response pulses, one cycle after the strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
        end else begin
            ack_o <= stb_i & ~dec_i.illegal;
            err_o <= stb_i & dec_i.illegal;
        end
    end

    // Fields hold between strobes
    always_ff @(posedge clk_i) begin
        if (stb_i) begin
            op_type_o <= dec_i.op_type;
            rd_o      <= dec_i.rd;
            rs1_o     <= dec_i.rs1;
            rs2_o     <= dec_i.rs2;
            imm_o     <= dec_i.imm;
            load_rs_o <= dec_i.load_rs;
        end
    end

endmodule

`default_nettype wire

//--- source/operand_extract.sv
/*
 * Operand extraction
 * Picks register indices and builds the sign-extended immediate per format
 */
`timescale 1ns/1ps
`default_nettype none

module operand_extract (
    input  riscv_isa_pkg::instr_t instr_i,
    decode_if.operand_mp          dec_o
);

    decode_out_pkg::reg_idx_t rd_field;
    decode_out_pkg::reg_idx_t rs1_field;
    decode_out_pkg::reg_idx_t rs2_field;
    logic                     sign;

    assign rd_field  = instr_i[11:7];
    assign rs1_field = instr_i[19:15];
    assign rs2_field = instr_i[24:20];
    assign sign      = instr_i[31];

    always_comb begin
        dec_o.rd      = '0;
        dec_o.rs1     = '0;
        dec_o.rs2     = '0;
        dec_o.imm     = '0;
        dec_o.load_rs = 1'b0;

        case (dec_o.fmt)
            riscv_isa_pkg::FMT_R: begin
                dec_o.rd      = rd_field;
                dec_o.rs1     = rs1_field;
                dec_o.rs2     = rs2_field;
                dec_o.load_rs = 1'b1;
            end
            riscv_isa_pkg::FMT_I: begin
                dec_o.rd      = rd_field;
                dec_o.rs1     = rs1_field;
                dec_o.imm     = {{20{sign}}, instr_i[31:20]};
                dec_o.load_rs = 1'b1;
            end
            riscv_isa_pkg::FMT_S: begin
                dec_o.rs1     = rs1_field;
                dec_o.rs2     = rs2_field;
                dec_o.imm     = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
                dec_o.load_rs = 1'b1;
            end
            riscv_isa_pkg::FMT_B: begin
                dec_o.rs1     = rs1_field;
                dec_o.rs2     = rs2_field;
                dec_o.imm     = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                                 instr_i[11:8], 1'b0};  // Even byte offset
                dec_o.load_rs = 1'b1;
            end
            riscv_isa_pkg::FMT_U: begin
                dec_o.rd  = rd_field;
                dec_o.imm = {instr_i[31:12], 12'b0};
            end
            riscv_isa_pkg::FMT_J: begin
                dec_o.rd  = rd_field;
                dec_o.imm = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                             instr_i[30:21], 1'b0};
            end
            default: ;  // SYS has no operands
        endcase
    end

endmodule

`default_nettype wire

//--- source/instr_type_decode.sv
/*
 * Instruction type decode
 * Maps opcode, funct3 and funct7/funct12 to an operation code and a format,
 * and flags every encoding outside the supported set
 */
`timescale 1ns/1ps
`default_nettype none

module instr_type_decode #(
    parameter bit ENABLE_M = 1'b1
) (
    input  riscv_isa_pkg::instr_t instr_i,
    decode_if.type_mp             dec_o
);

    riscv_isa_pkg::opcode_t opcode;
    riscv_isa_pkg::funct3_t funct3;
    riscv_isa_pkg::funct7_t funct7;
    logic [11:0]            funct12;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign funct12 = instr_i[31:20];

    always_comb begin
        dec_o.op_type = decode_out_pkg::OP_ADDI;
        dec_o.fmt     = riscv_isa_pkg::FMT_I;
        dec_o.illegal = 1'b0;

        case (opcode)
            riscv_isa_pkg::OPC_LUI: begin
                dec_o.op_type = decode_out_pkg::OP_LUI;
                dec_o.fmt     = riscv_isa_pkg::FMT_U;
            end
            riscv_isa_pkg::OPC_AUIPC: begin
                dec_o.op_type = decode_out_pkg::OP_AUIPC;
                dec_o.fmt     = riscv_isa_pkg::FMT_U;
            end
            riscv_isa_pkg::OPC_JAL: begin
                dec_o.op_type = decode_out_pkg::OP_JAL;
                dec_o.fmt     = riscv_isa_pkg::FMT_J;
            end
            riscv_isa_pkg::OPC_JALR: begin
                dec_o.op_type = decode_out_pkg::OP_JALR;
                dec_o.illegal = (funct3 != 3'b000);
            end
            riscv_isa_pkg::OPC_BRANCH: begin
                dec_o.fmt = riscv_isa_pkg::FMT_B;
                case (funct3)
                    3'b000:  dec_o.op_type = decode_out_pkg::OP_BEQ;
                    3'b001:  dec_o.op_type = decode_out_pkg::OP_BNE;
                    3'b100:  dec_o.op_type = decode_out_pkg::OP_BLT;
                    3'b101:  dec_o.op_type = decode_out_pkg::OP_BGE;
                    3'b110:  dec_o.op_type = decode_out_pkg::OP_BLTU;
                    3'b111:  dec_o.op_type = decode_out_pkg::OP_BGEU;
                    default: dec_o.illegal = 1'b1;
                endcase
            end
            riscv_isa_pkg::OPC_LOAD: begin
                case (funct3)
                    3'b000:  dec_o.op_type = decode_out_pkg::OP_LB;
                    3'b001:  dec_o.op_type = decode_out_pkg::OP_LH;
                    3'b010:  dec_o.op_type = decode_out_pkg::OP_LW;
                    3'b100:  dec_o.op_type = decode_out_pkg::OP_LBU;
                    3'b101:  dec_o.op_type = decode_out_pkg::OP_LHU;
                    default: dec_o.illegal = 1'b1;
                endcase
            end
            riscv_isa_pkg::OPC_STORE: begin
                dec_o.fmt = riscv_isa_pkg::FMT_S;
                case (funct3)
                    3'b000:  dec_o.op_type = decode_out_pkg::OP_SB;
                    3'b001:  dec_o.op_type = decode_out_pkg::OP_SH;
                    3'b010:  dec_o.op_type = decode_out_pkg::OP_SW;
                    default: dec_o.illegal = 1'b1;
                endcase
            end
            riscv_isa_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b000: dec_o.op_type = decode_out_pkg::OP_ADDI;
                    3'b010: dec_o.op_type = decode_out_pkg::OP_SLTI;
                    3'b011: dec_o.op_type = decode_out_pkg::OP_SLTIU;
                    3'b100: dec_o.op_type = decode_out_pkg::OP_XORI;
                    3'b110: dec_o.op_type = decode_out_pkg::OP_ORI;
                    3'b111: dec_o.op_type = decode_out_pkg::OP_ANDI;
                    3'b001: begin
                        dec_o.op_type = decode_out_pkg::OP_SLLI;
                        dec_o.illegal = (funct7 != riscv_isa_pkg::F7_BASE);
                    end
                    default: begin  // Shift right, arithmetic when funct7 is ALT
                        if (funct7 == riscv_isa_pkg::F7_BASE) begin
                            dec_o.op_type = decode_out_pkg::OP_SRLI;
                        end else if (funct7 == riscv_isa_pkg::F7_ALT) begin
                            dec_o.op_type = decode_out_pkg::OP_SRAI;
                        end else begin
                            dec_o.illegal = 1'b1;
                        end
                    end
                endcase
            end
            riscv_isa_pkg::OPC_OP: begin
                dec_o.fmt = riscv_isa_pkg::FMT_R;
                if (funct7 == riscv_isa_pkg::F7_BASE) begin
                    case (funct3)
                        3'b000:  dec_o.op_type = decode_out_pkg::OP_ADD;
                        3'b001:  dec_o.op_type = decode_out_pkg::OP_SLL;
                        3'b010:  dec_o.op_type = decode_out_pkg::OP_SLT;
                        3'b011:  dec_o.op_type = decode_out_pkg::OP_SLTU;
                        3'b100:  dec_o.op_type = decode_out_pkg::OP_XOR;
                        3'b101:  dec_o.op_type = decode_out_pkg::OP_SRL;
                        3'b110:  dec_o.op_type = decode_out_pkg::OP_OR;
                        default: dec_o.op_type = decode_out_pkg::OP_AND;
                    endcase
                end else if (funct7 == riscv_isa_pkg::F7_ALT) begin
                    case (funct3)
                        3'b000:  dec_o.op_type = decode_out_pkg::OP_SUB;
                        3'b101:  dec_o.op_type = decode_out_pkg::OP_SRA;
                        default: dec_o.illegal = 1'b1;
                    endcase
                end else if (funct7 == riscv_isa_pkg::F7_MULDIV && ENABLE_M) begin
                    // M opcodes follow funct3 order from MUL
                    dec_o.op_type = decode_out_pkg::OP_MUL + decode_out_pkg::op_type_t'(funct3);
                end else begin
                    dec_o.illegal = 1'b1;
                end
            end
            riscv_isa_pkg::OPC_FENCE: begin
                dec_o.op_type = decode_out_pkg::OP_FENCE;
                dec_o.illegal = (funct3 != 3'b000);
            end
            riscv_isa_pkg::OPC_SYSTEM: begin
                dec_o.fmt     = riscv_isa_pkg::FMT_SYS;
                dec_o.illegal = (funct3 != 3'b000);  // CSR accesses are rejected
                case (funct12)
                    riscv_isa_pkg::F12_ECALL:  dec_o.op_type = decode_out_pkg::OP_ECALL;
                    riscv_isa_pkg::F12_EBREAK: dec_o.op_type = decode_out_pkg::OP_EBREAK;
                    riscv_isa_pkg::F12_MRET:   dec_o.op_type = decode_out_pkg::OP_MRET;
                    riscv_isa_pkg::F12_WFI:    dec_o.op_type = decode_out_pkg::OP_WFI;
                    default:                   dec_o.illegal = 1'b1;
                endcase
            end
            default: dec_o.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- source/decode_if.sv
/*
 * Combinational decode result shared by the decode stages
 */
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

    decode_out_pkg::op_type_t op_type;
    riscv_isa_pkg::instr_fmt_t fmt;
    logic                      illegal;
    decode_out_pkg::reg_idx_t  rd;
    decode_out_pkg::reg_idx_t  rs1;
    decode_out_pkg::reg_idx_t  rs2;
    decode_out_pkg::imm_t      imm;
    logic                      load_rs;  // Sources come from the register file

    modport type_mp (output op_type, output fmt, output illegal);
    modport operand_mp (input fmt, output rd, output rs1, output rs2, output imm, output load_rs);
    modport result_mp (input op_type, input illegal, input rd, input rs1, input rs2,
                       input imm, input load_rs);

endinterface

`default_nettype wire

//--- source/decode_out_pkg.sv
/*
 * Decoder result types
 * Operation codes, register index and immediate widths
 */
`default_nettype none

package decode_out_pkg;

    typedef logic [6:0]  op_type_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] imm_t;

    // ============================================================
    // Operation codes, one per instruction
    // ============================================================
    localparam op_type_t
        OP_LUI = 7'd0, OP_AUIPC = 7'd1, OP_JAL = 7'd2, OP_JALR = 7'd3,
        // Branches
        OP_BEQ = 7'd4, OP_BNE = 7'd5, OP_BLT = 7'd6, OP_BGE = 7'd7,
        OP_BLTU = 7'd8, OP_BGEU = 7'd9,
        // Loads and stores
        OP_LB = 7'd10, OP_LH = 7'd11, OP_LW = 7'd12, OP_LBU = 7'd13, OP_LHU = 7'd14,
        OP_SB = 7'd15, OP_SH = 7'd16, OP_SW = 7'd17,
        // Register-immediate ALU
        OP_ADDI = 7'd18, OP_SLTI = 7'd19, OP_SLTIU = 7'd20, OP_XORI = 7'd21,
        OP_ORI = 7'd22, OP_ANDI = 7'd23, OP_SLLI = 7'd24, OP_SRLI = 7'd25,
        OP_SRAI = 7'd26,
        // Register-register ALU
        OP_ADD = 7'd27, OP_SUB = 7'd28, OP_SLL = 7'd29, OP_SLT = 7'd30,
        OP_SLTU = 7'd31, OP_XOR = 7'd32, OP_SRL = 7'd33, OP_SRA = 7'd34,
        OP_OR = 7'd35, OP_AND = 7'd36,
        // Fence and system
        OP_FENCE = 7'd37, OP_ECALL = 7'd38, OP_EBREAK = 7'd39, OP_MRET = 7'd40,
        OP_WFI = 7'd41,
        // RV32M, in funct3 order
        OP_MUL = 7'd42, OP_MULH = 7'd43, OP_MULHSU = 7'd44, OP_MULHU = 7'd45,
        OP_DIV = 7'd46, OP_DIVU = 7'd47, OP_REM = 7'd48, OP_REMU = 7'd49;

endpackage

`default_nettype wire

//--- source/riscv_isa_pkg.sv
/*
 * RV32I/M ISA encodings
 * Opcode, funct7 and funct12 values, field types and format codes
 */
`default_nettype none

package riscv_isa_pkg;

    typedef logic [31:0] instr_t;      // Raw instruction word
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [2:0]  instr_fmt_t;  // Operand layout class

    // ============================================================
    // Major opcodes
    // ============================================================
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_FENCE  = 7'b0001111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;  // SUB, SRA, SRAI
    localparam funct7_t F7_MULDIV = 7'b0000001;  // RV32M

    // SYSTEM with funct3 of zero, selected by bits 31:20
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;
    localparam logic [11:0] F12_WFI    = 12'h105;

    // ============================================================
    // Instruction formats
    // ============================================================
    localparam instr_fmt_t FMT_R   = 3'd0;
    localparam instr_fmt_t FMT_I   = 3'd1;
    localparam instr_fmt_t FMT_S   = 3'd2;
    localparam instr_fmt_t FMT_B   = 3'd3;
    localparam instr_fmt_t FMT_U   = 3'd4;
    localparam instr_fmt_t FMT_J   = 3'd5;
    localparam instr_fmt_t FMT_SYS = 3'd6;  // No operands, no immediate

endpackage

`default_nettype wire
